// ==== apb_arbiter.sv ====
// round-robin arbiter between two request-level masters, driving APB phases to the RAM
`timescale 1ns/1ps
`default_nettype none

module apb_arbiter (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               m0_psel,
    input  wire logic               m0_pwrite,
    input  wire apb_pkg::apb_addr_t m0_paddr,
    input  wire apb_pkg::apb_data_t m0_pwdata,
    input  wire apb_pkg::apb_strb_t m0_pstrb,
    output logic                    m0_pready,
    output apb_pkg::apb_data_t      m0_prdata,
    input  wire logic               m1_psel,
    input  wire logic               m1_pwrite,
    input  wire apb_pkg::apb_addr_t m1_paddr,
    input  wire apb_pkg::apb_data_t m1_pwdata,
    input  wire apb_pkg::apb_strb_t m1_pstrb,
    output logic                    m1_pready,
    output apb_pkg::apb_data_t      m1_prdata,
    output logic                    s_psel,
    output logic                    s_penable,
    output logic                    s_pwrite,
    output apb_pkg::apb_addr_t      s_paddr,
    output apb_pkg::apb_data_t      s_pwdata,
    output apb_pkg::apb_strb_t      s_pstrb,
    input  wire logic               s_pready,
    input  wire apb_pkg::apb_data_t s_prdata
);
    import apb_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SETUP,
        ARB_ACCESS
    } arb_state_t;

    arb_state_t state;
    // grant high selects m1
    logic       grant;
    logic       last_m1;
    logic       done_m0;
    logic       done_m1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ARB_IDLE;
            grant <= 1'b0;
            // pretend m1 went last so m0 wins the first tie
            last_m1 <= 1'b1;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (m0_psel || m1_psel) begin
                        state <= ARB_SETUP;
                        grant <= m1_psel && (!m0_psel || !last_m1);
                    end
                end
                ARB_SETUP: begin
                    state <= ARB_ACCESS;
                end
                ARB_ACCESS: begin
                    if (s_pready) begin
                        state <= ARB_IDLE;
                        last_m1 <= grant;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // request mux toward the RAM
    assign s_psel = (state != ARB_IDLE);
    assign s_penable = (state == ARB_ACCESS);
    assign s_pwrite = grant ? m1_pwrite : m0_pwrite;
    assign s_paddr = grant ? m1_paddr : m0_paddr;
    assign s_pwdata = grant ? m1_pwdata : m0_pwdata;
    assign s_pstrb = grant ? m1_pstrb : m0_pstrb;

    // response goes back to the owner only
    assign done_m0 = (state == ARB_ACCESS) && s_pready && !grant;
    assign done_m1 = (state == ARB_ACCESS) && s_pready && grant;
    assign m0_pready = done_m0;
    assign m1_pready = done_m1;
    assign m0_prdata = done_m0 ? s_prdata : apb_data_t'(0);
    assign m1_prdata = done_m1 ? s_prdata : apb_data_t'(0);

endmodule

`default_nettype wire

// ==== apb_cmd_master.sv ====
// single-transfer APB master started by a strobe, returns read data and a done pulse
`timescale 1ns/1ps
`default_nettype none

module apb_cmd_master (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               cmd_start,
    input  wire logic               cmd_write,
    input  wire apb_pkg::apb_addr_t cmd_addr,
    input  wire apb_pkg::apb_data_t cmd_wdata,
    input  wire apb_pkg::apb_strb_t cmd_strb,
    output logic                    cmd_busy,
    output logic                    cmd_done,
    output apb_pkg::apb_data_t      cmd_rdata,
    output logic                    psel,
    output logic                    pwrite,
    output apb_pkg::apb_addr_t      paddr,
    output apb_pkg::apb_data_t      pwdata,
    output apb_pkg::apb_strb_t      pstrb,
    input  wire logic               pready,
    input  wire apb_pkg::apb_data_t prdata
);
    import apb_pkg::*;

    logic accept;
    logic finish;

    assign accept = cmd_start && !cmd_busy;
    assign finish = psel && pready;

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_busy <= 1'b0;
            cmd_done <= 1'b0;
            psel <= 1'b0;
        end else begin
            cmd_done <= finish;
            if (accept) begin
                cmd_busy <= 1'b1;
                psel <= 1'b1;
            end else if (finish) begin
                cmd_busy <= 1'b0;
                psel <= 1'b0;
            end
        end
    end

    // request held stable while psel is up
    always_ff @(posedge clk) begin
        if (accept) begin
            pwrite <= cmd_write;
            paddr <= cmd_addr;
            pwdata <= cmd_wdata;
            pstrb <= cmd_strb;
        end
        if (finish && !pwrite) begin
            cmd_rdata <= prdata;
        end
    end

endmodule

`default_nettype wire

// ==== apb_fill_engine.sv ====
// block-fill APB master writing one value over a run of consecutive RAM words
`timescale 1ns/1ps
`default_nettype none

module apb_fill_engine (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   fill_start,
    input  wire ram_pkg::ram_word_idx_t fill_base,
    input  wire ram_pkg::ram_word_idx_t fill_count,
    input  wire apb_pkg::apb_data_t     fill_value,
    output logic                        fill_busy,
    output logic                        fill_done,
    output logic                        psel,
    output logic                        pwrite,
    output apb_pkg::apb_addr_t          paddr,
    output apb_pkg::apb_data_t          pwdata,
    output apb_pkg::apb_strb_t          pstrb,
    input  wire logic                   pready
);
    import apb_pkg::*;
    import ram_pkg::*;

    localparam int CNT_W = $clog2(RAM_WORDS);
    localparam int BYTE_SHIFT = $clog2(APB_STRB_W);

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQ,
        FILL_GAP,
        FILL_END
    } fill_state_t;

    fill_state_t      state;
    ram_word_idx_t    word_idx;
    logic [CNT_W-1:0] remaining;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILL_IDLE;
            fill_busy <= 1'b0;
            fill_done <= 1'b0;
            psel <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            case (state)
                FILL_IDLE: begin
                    if (fill_start) begin
                        fill_busy <= 1'b1;
                        psel <= (fill_count != '0);
                        state <= (fill_count != '0) ? FILL_REQ : FILL_END;
                    end
                end
                FILL_REQ: begin
                    if (pready) begin
                        psel <= 1'b0;
                        state <= (remaining == CNT_W'(1)) ? FILL_END : FILL_GAP;
                    end
                end
                // psel stays low for one cycle between words
                FILL_GAP: begin
                    psel <= 1'b1;
                    state <= FILL_REQ;
                end
                FILL_END: begin
                    fill_busy <= 1'b0;
                    fill_done <= 1'b1;
                    state <= FILL_IDLE;
                end
                default: begin
                    state <= FILL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FILL_IDLE && fill_start) begin
            word_idx <= fill_base;
            remaining <= fill_count;
            pwdata <= fill_value;
        end else if (state == FILL_REQ && pready) begin
            // index wraps around the end of the RAM
            word_idx <= word_idx + 1'b1;
            remaining <= remaining - CNT_W'(1);
        end
    end

    assign paddr = apb_addr_t'(word_idx) << BYTE_SHIFT;
    assign pwrite = 1'b1;
    assign pstrb = '1;

endmodule

`default_nettype wire

// ==== apb_pkg.sv ====
// APB bus widths and vector types shared by every master, the arbiter and the RAM
`default_nettype none

package apb_pkg;

    // byte address width on every APB port
    localparam int APB_ADDR_W = 16;

    // data word width
    localparam int APB_DATA_W = 32;

    // one strobe bit per byte lane
    localparam int APB_STRB_W = APB_DATA_W / 8;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;

    typedef logic [APB_DATA_W-1:0] apb_data_t;

    typedef logic [APB_STRB_W-1:0] apb_strb_t;

endpackage

`default_nettype wire

// ==== apb_ram.sv ====
// APB slave RAM with byte-lane writes, one wait state and an optional output register
`timescale 1ns/1ps
`default_nettype none

module apb_ram #(
    parameter int ADDR_W = 10,
    parameter bit PIPELINE_OUTPUT = 1'b0
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               psel,
    input  wire logic               penable,
    input  wire logic               pwrite,
    input  wire apb_pkg::apb_addr_t paddr,
    input  wire apb_pkg::apb_data_t pwdata,
    input  wire apb_pkg::apb_strb_t pstrb,
    output logic                    pready,
    output apb_pkg::apb_data_t      prdata
);
    import apb_pkg::*;

    localparam int BYTE_SHIFT = $clog2(APB_STRB_W);
    localparam int IDX_W = ADDR_W - BYTE_SHIFT;
    localparam int DEPTH = 2 ** IDX_W;
    localparam int BYTE_W = APB_DATA_W / APB_STRB_W;

    apb_data_t        mem [DEPTH];
    logic [IDX_W-1:0] word_idx;
    logic             rsp_busy;
    logic             access;
    logic             pready_reg;
    logic             pready_pipe;
    apb_data_t        prdata_reg;
    apb_data_t        prdata_pipe;

    // contents start at zero, reset leaves them alone
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign word_idx = paddr[ADDR_W-1:BYTE_SHIFT];

    // no new access while a response is still on its way out
    assign rsp_busy = pready_reg || (PIPELINE_OUTPUT && pready_pipe);
    assign access = psel && penable && !rsp_busy;

    always @(posedge clk) begin
        if (access && pwrite) begin
            for (int i = 0; i < APB_STRB_W; i++) begin
                if (pstrb[i]) begin
                    mem[word_idx][BYTE_W*i +: BYTE_W] <= pwdata[BYTE_W*i +: BYTE_W];
                end
            end
        end
        if (access && !pwrite) begin
            prdata_reg <= mem[word_idx];
        end
        prdata_pipe <= prdata_reg;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pready_reg <= 1'b0;
            pready_pipe <= 1'b0;
        end else begin
            pready_reg <= access;
            pready_pipe <= pready_reg;
        end
    end

    assign pready = PIPELINE_OUTPUT ? pready_pipe : pready_reg;
    assign prdata = PIPELINE_OUTPUT ? prdata_pipe : prdata_reg;

endmodule

`default_nettype wire

// ==== apb_ram_subsys.sv ====
// shared RAM subsystem with a command master and a fill engine behind one arbiter
`timescale 1ns/1ps
`default_nettype none

module apb_ram_subsys (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   cmd_start,
    input  wire logic                   cmd_write,
    input  wire apb_pkg::apb_addr_t     cmd_addr,
    input  wire apb_pkg::apb_data_t     cmd_wdata,
    input  wire apb_pkg::apb_strb_t     cmd_strb,
    output logic                        cmd_busy,
    output logic                        cmd_done,
    output apb_pkg::apb_data_t          cmd_rdata,
    input  wire logic                   fill_start,
    input  wire ram_pkg::ram_word_idx_t fill_base,
    input  wire ram_pkg::ram_word_idx_t fill_count,
    input  wire apb_pkg::apb_data_t     fill_value,
    output logic                        fill_busy,
    output logic                        fill_done
);
    import apb_pkg::*;
    import ram_pkg::*;

    // m0 is the command master, m1 the fill engine
    logic      m0_psel, m0_pwrite, m0_pready;
    apb_addr_t m0_paddr;
    apb_data_t m0_pwdata, m0_prdata;
    apb_strb_t m0_pstrb;
    logic      m1_psel, m1_pwrite, m1_pready;
    apb_addr_t m1_paddr;
    apb_data_t m1_pwdata;
    apb_strb_t m1_pstrb;
    logic      s_psel, s_penable, s_pwrite, s_pready;
    apb_addr_t s_paddr;
    apb_data_t s_pwdata, s_prdata;
    apb_strb_t s_pstrb;

    apb_cmd_master u_cmd (.clk, .rst, .cmd_start, .cmd_write, .cmd_addr, .cmd_wdata,
        .cmd_strb, .cmd_busy, .cmd_done, .cmd_rdata, .psel(m0_psel), .pwrite(m0_pwrite),
        .paddr(m0_paddr), .pwdata(m0_pwdata), .pstrb(m0_pstrb), .pready(m0_pready),
        .prdata(m0_prdata));

    apb_fill_engine u_fill (.clk, .rst, .fill_start, .fill_base, .fill_count, .fill_value,
        .fill_busy, .fill_done, .psel(m1_psel), .pwrite(m1_pwrite), .paddr(m1_paddr),
        .pwdata(m1_pwdata), .pstrb(m1_pstrb), .pready(m1_pready));

    // the fill engine only writes, so its read data is left open
    apb_arbiter u_arb (.clk, .rst, .m0_psel, .m0_pwrite, .m0_paddr, .m0_pwdata, .m0_pstrb,
        .m0_pready, .m0_prdata, .m1_psel, .m1_pwrite, .m1_paddr, .m1_pwdata, .m1_pstrb,
        .m1_pready, .m1_prdata(), .s_psel, .s_penable, .s_pwrite, .s_paddr, .s_pwdata,
        .s_pstrb, .s_pready, .s_prdata);

    apb_ram #(.ADDR_W(RAM_ADDR_W), .PIPELINE_OUTPUT(RAM_PIPELINE_OUTPUT)) u_ram (.clk, .rst,
        .psel(s_psel), .penable(s_penable), .pwrite(s_pwrite), .paddr(s_paddr),
        .pwdata(s_pwdata), .pstrb(s_pstrb), .pready(s_pready), .prdata(s_prdata));

endmodule

`default_nettype wire

// ==== ram_pkg.sv ====
// shared RAM geometry and configuration for the subsystem
`default_nettype none

package ram_pkg;

    // byte address bits decoded by the RAM, 256 words of 4 bytes
    localparam int RAM_ADDR_W = 10;
    localparam int RAM_WORDS = 256;

    // extra register stage on pready and prdata
    localparam bit RAM_PIPELINE_OUTPUT = 1'b0;

    typedef logic [7:0] ram_word_idx_t;

endpackage

`default_nettype wire

// ==== sources.f ====
apb_pkg.sv
ram_pkg.sv
apb_ram.sv
apb_arbiter.sv
apb_cmd_master.sv
apb_fill_engine.sv
apb_ram_subsys.sv
tb_apb_ram_subsys.sv

// ==== tb_apb_ram_subsys.sv ====
// directed testbench for the shared APB RAM subsystem with its command master and fill engine
`timescale 1ns/1ps
`default_nettype none

module tb_apb_ram_subsys;
    import apb_pkg::*;
    import ram_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 5;
    localparam int RESET_CYCLES = 16;
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int BYTE_SHIFT = $clog2(APB_STRB_W);

    logic          clk;
    logic          rst;
    logic          cmd_start;
    logic          cmd_write;
    apb_addr_t     cmd_addr;
    apb_data_t     cmd_wdata;
    apb_strb_t     cmd_strb;
    logic          cmd_busy;
    logic          cmd_done;
    apb_data_t     cmd_rdata;
    logic          fill_start;
    ram_word_idx_t fill_base;
    ram_word_idx_t fill_count;
    apb_data_t     fill_value;
    logic          fill_busy;
    logic          fill_done;

    // reference copy of the RAM contents
    apb_data_t ref_mem [RAM_WORDS];
    integer    seed;

    apb_ram_subsys u_dut (.clk, .rst, .cmd_start, .cmd_write, .cmd_addr, .cmd_wdata,
        .cmd_strb, .cmd_busy, .cmd_done, .cmd_rdata, .fill_start, .fill_base, .fill_count,
        .fill_value, .fill_busy, .fill_done);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // inputs change a little after the rising edge
    task automatic next_slot();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input apb_data_t expected,
                               input apb_data_t actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("MISMATCH %s expected %h actual %h",
                name, expected, actual));
        end
    endtask

    // byte lanes with a strobe take the new data, the rest keep the old word
    function automatic apb_data_t merge_lanes(input apb_data_t old_word,
                                              input apb_data_t new_word,
                                              input apb_strb_t strb);
        apb_data_t result;
        result = old_word;
        for (int i = 0; i < APB_STRB_W; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    task automatic issue_command(input logic write, input ram_word_idx_t idx,
                                 input apb_data_t wdata, input apb_strb_t strb,
                                 output apb_data_t rdata);
        int waited;
        waited = 0;
        cmd_write = write;
        cmd_addr = apb_addr_t'(idx) << BYTE_SHIFT;
        cmd_wdata = wdata;
        cmd_strb = strb;
        cmd_start = 1'b1;
        next_slot();
        cmd_start = 1'b0;
        check_value("cmd busy after start", 1, cmd_busy);
        while (!cmd_done) begin
            if (waited >= TIMEOUT_CYCLES) begin
                stop_with_failure(write ? "command write never finished"
                                        : "command read never finished");
            end
            next_slot();
            waited++;
        end
        check_value("cmd busy at done", 0, cmd_busy);
        rdata = cmd_rdata;
    endtask

    task automatic cmd_write_word(input ram_word_idx_t idx, input apb_data_t data,
                                  input apb_strb_t strb);
        apb_data_t unused;
        issue_command(1'b1, idx, data, strb, unused);
        ref_mem[idx] = merge_lanes(ref_mem[idx], data, strb);
    endtask

    task automatic cmd_read_word(input ram_word_idx_t idx, output apb_data_t data);
        issue_command(1'b0, idx, '0, '0, data);
    endtask

    task automatic check_word(input string name, input ram_word_idx_t idx);
        apb_data_t data;
        cmd_read_word(idx, data);
        check_value($sformatf("%s word %0d", name, idx), ref_mem[idx], data);
    endtask

    task automatic run_fill(input ram_word_idx_t base, input ram_word_idx_t count,
                            input apb_data_t value, output int cycles);
        int waited;
        waited = 0;
        fill_base = base;
        fill_count = count;
        fill_value = value;
        fill_start = 1'b1;
        next_slot();
        fill_start = 1'b0;
        check_value("fill busy after start", 1, fill_busy);
        while (!fill_done) begin
            if (waited >= TIMEOUT_CYCLES) begin
                stop_with_failure("block fill never finished");
            end
            next_slot();
            waited++;
        end
        cycles = waited;
        for (int i = 0; i < count; i++) begin
            ref_mem[ram_word_idx_t'(base + i)] = value;
        end
    endtask

    task automatic test_reset_state();
        check_value("reset cmd_busy", 0, cmd_busy);
        check_value("reset cmd_done", 0, cmd_done);
        check_value("reset fill_busy", 0, fill_busy);
        check_value("reset fill_done", 0, fill_done);
        check_word("reset", 8'd0);
        check_word("reset", 8'd255);
        repeat (4) begin
            check_word("reset", ram_word_idx_t'($random(seed)));
        end
    endtask

    task automatic test_full_word();
        ram_word_idx_t idx_list [8];
        for (int i = 0; i < 8; i++) begin
            idx_list[i] = ram_word_idx_t'($random(seed));
            cmd_write_word(idx_list[i], apb_data_t'($random(seed)), 4'hf);
        end
        for (int i = 0; i < 8; i++) begin
            check_word("full word", idx_list[i]);
        end
    endtask

    task automatic test_byte_strobes();
        apb_data_t data;
        cmd_write_word(8'd17, 32'h1122_3344, 4'hf);
        cmd_write_word(8'd17, 32'haabb_ccdd, 4'b0101);
        cmd_read_word(8'd17, data);
        check_value("byte strobes lanes 0 and 2", 32'h11bb_33dd, data);
        cmd_write_word(8'd17, apb_data_t'($random(seed)), 4'b1000);
        check_word("byte strobes lane 3", 8'd17);
    endtask

    task automatic test_block_fill();
        int cycles;
        // neighbours get known values so an overrun shows up
        cmd_write_word(8'd249, apb_data_t'($random(seed)), 4'hf);
        cmd_write_word(8'd4, apb_data_t'($random(seed)), 4'hf);
        run_fill(8'd250, 8'd10, apb_data_t'($random(seed)), cycles);
        for (int i = 0; i < 12; i++) begin
            check_word("block fill", ram_word_idx_t'(249 + i));
        end
        cmd_write_word(8'd100, apb_data_t'($random(seed)), 4'hf);
        run_fill(8'd100, 8'd0, 32'hdead_beef, cycles);
        check_value("zero fill latency", 2, cycles + 1);
        for (int i = 99; i < 102; i++) begin
            check_word("zero fill", ram_word_idx_t'(i));
        end
    endtask

    task automatic test_concurrent();
        int cycles;
        int waited;
        waited = 0;
        fork
            begin
                run_fill(8'd64, 8'd32, apb_data_t'($random(seed)), cycles);
            end
            begin
                while (!fill_busy) begin
                    if (waited >= TIMEOUT_CYCLES) begin
                        stop_with_failure("fill engine never became busy");
                    end
                    next_slot();
                    waited++;
                end
                for (int k = 0; k < 4; k++) begin
                    check_value("fill busy during command", 1, fill_busy);
                    cmd_write_word(ram_word_idx_t'(200 + k), 32'h5a00_0000 + k, 4'hf);
                end
            end
        join
        for (int i = 63; i < 97; i++) begin
            check_word("concurrent fill", ram_word_idx_t'(i));
        end
        for (int i = 200; i < 204; i++) begin
            check_word("concurrent command", ram_word_idx_t'(i));
        end
    endtask

    initial begin
        seed = 76;
        rst = 1'b1;
        cmd_start = 1'b0;
        cmd_write = 1'b0;
        cmd_addr = '0;
        cmd_wdata = '0;
        cmd_strb = '0;
        fill_start = 1'b0;
        fill_base = '0;
        fill_count = '0;
        fill_value = '0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        next_slot();
        test_reset_state();
        test_full_word();
        test_byte_strobes();
        test_block_fill();
        test_concurrent();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
